// File: common/core_pkg.sv
// ####################
// shared sizes and types of the RV32I front end
// FB_PTR_W must equal log2(FB_DEPTH); a line holds FETCH_WIDTH words
// ####################

package core_pkg;

  localparam int XLEN         = 32;
  localparam int FETCH_WIDTH  = 4;
  localparam int DECODE_WIDTH = 4;
  localparam int FB_DEPTH     = 16;
  localparam int FB_PTR_W     = 4;
  localparam int LINE_BYTES   = FETCH_WIDTH * 4;
  localparam int POP_W        = $clog2(DECODE_WIDTH + 1);

  typedef logic [XLEN-1:0]           addr_t;
  typedef logic [31:0]               inst_t;
  typedef logic [4:0]                reg_idx_t;
  typedef logic [FETCH_WIDTH*32-1:0] line_t;
  typedef logic [6:0]                opcode_t;

  localparam addr_t RESET_PC = '0;

  // rv32i major opcodes
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_AUIPC    = 7'b0010111;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_LOAD     = 7'b0000011;
  localparam opcode_t OPC_STORE    = 7'b0100011;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_MISC_MEM = 7'b0001111;
  localparam opcode_t OPC_SYSTEM   = 7'b1110011;

  typedef enum logic [2:0] {
    uop_alu,
    uop_branch,
    uop_load,
    uop_store,
    uop_system,
    uop_illegal
  } uop_type_t;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fb_entry_t;

  // type is a keyword, hence uop_type
  typedef struct packed {
    addr_t           pc;
    inst_t           inst;
    uop_type_t       uop_type;
    reg_idx_t        rd;
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    logic            rd_valid;
    logic [XLEN-1:0] imm;
  } micro_op_t;

endpackage

// File: decode/inst_decode.sv
// ####################
// four RV32I decode lanes with an output register
// decode_stall holds the outputs and pops nothing
// ####################

module inst_decode (
  input  logic                                           clock,
  input  logic                                           reset,
  input  core_pkg::fb_entry_t [core_pkg::DECODE_WIDTH-1:0] fb_insts,
  input  logic [core_pkg::DECODE_WIDTH-1:0]              fb_valid,
  input  logic                                           decode_stall,
  output logic [core_pkg::POP_W-1:0]                     pop_count,
  output core_pkg::micro_op_t [core_pkg::DECODE_WIDTH-1:0] uops,
  output logic [core_pkg::DECODE_WIDTH-1:0]              uop_valid
);

  import core_pkg::*;

  micro_op_t [DECODE_WIDTH-1:0] dec_uops;

  function automatic logic [XLEN-1:0] imm_i(inst_t w);
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic logic [XLEN-1:0] imm_s(inst_t w);
    return {{20{w[31]}}, w[31:25], w[11:7]};
  endfunction

  function automatic logic [XLEN-1:0] imm_b(inst_t w);
    return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic logic [XLEN-1:0] imm_u(inst_t w);
    return {w[31:12], 12'b0};
  endfunction

  function automatic logic [XLEN-1:0] imm_j(inst_t w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic micro_op_t decode_one(fb_entry_t ent);
    micro_op_t u;
    opcode_t   opc;
    logic      is_jump;
    opc      = ent.inst[6:0];
    is_jump  = (opc == OPC_JAL) || (opc == OPC_JALR);
    u.pc     = ent.pc;
    u.inst   = ent.inst;
    u.rd     = ent.inst[11:7];
    u.rs1    = ent.inst[19:15];
    u.rs2    = ent.inst[24:20];
    u.imm    = '0;
    u.uop_type = uop_illegal;
    case (opc)
      OPC_OP:       u.uop_type = uop_alu;
      OPC_OP_IMM: begin
        u.uop_type = uop_alu;
        u.imm      = imm_i(ent.inst);
      end
      OPC_LUI, OPC_AUIPC: begin
        u.uop_type = uop_alu;
        u.imm      = imm_u(ent.inst);
      end
      OPC_BRANCH: begin
        u.uop_type = uop_branch;
        u.imm      = imm_b(ent.inst);
      end
      OPC_JAL: begin
        u.uop_type = uop_branch;
        u.imm      = imm_j(ent.inst);
      end
      OPC_JALR: begin
        u.uop_type = uop_branch;
        u.imm      = imm_i(ent.inst);
      end
      OPC_LOAD: begin
        u.uop_type = uop_load;
        u.imm      = imm_i(ent.inst);
      end
      OPC_STORE: begin
        u.uop_type = uop_store;
        u.imm      = imm_s(ent.inst);
      end
      OPC_SYSTEM, OPC_MISC_MEM: begin
        u.uop_type = uop_system;
        u.imm      = imm_i(ent.inst);
      end
      default: ;
    endcase
    // conditional branches and system ops never write rd here
    u.rd_valid = (u.rd != '0) &&
                 (u.uop_type == uop_alu || u.uop_type == uop_load || is_jump);
    return u;
  endfunction

  always_comb begin
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      dec_uops[k] = decode_one(fb_insts[k]);
    end
  end

  // lanes are contiguous so the pop is a plain count
  always_comb begin
    pop_count = '0;
    if (!decode_stall) begin
      for (int k = 0; k < DECODE_WIDTH; k++) begin
        if (fb_valid[k]) begin
          pop_count = pop_count + POP_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      uop_valid <= '0;
    end else if (!decode_stall) begin
      uop_valid <= fb_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!decode_stall) begin
      uops <= dec_uops;
    end
  end

  for (genvar k = 0; k < DECODE_WIDTH; k++) begin : g_chk
    a_store_no_rd: assert property (
      @(posedge clock) disable iff (reset)
      uop_valid[k] |-> !(uops[k].rd_valid && uops[k].uop_type == uop_store)
    ) else $error("lane %0d store with rd_valid at pc %h", k, uops[k].pc);
  end

endmodule

// File: dv/frontend_tb.sv
// ####################
// front end testbench, random image and stall bursts, seed 9531
// checks order, decode fields, stall hold and fetch freeze
// ####################

module frontend_tb;

  import core_pkg::*;

  localparam int N_INSTS        = 64;
  localparam int RESET_CYCLES   = 5;
  localparam int LONG_STALL     = 40;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_INSTS * 8 + LONG_STALL;

  logic                         clock;
  logic                         reset;
  logic                         decode_stall;
  line_t                        icache_data;
  logic                         icache_data_valid;
  addr_t                        icache_addr;
  micro_op_t [DECODE_WIDTH-1:0] uops;
  logic [DECODE_WIDTH-1:0]      uop_valid;
  inst_t [63:0]                 image;

  micro_op_t [DECODE_WIDTH-1:0] prev_uops;
  logic [DECODE_WIDTH-1:0]      prev_valid;
  logic                         stall_seen = 1'b0;
  addr_t                        expect_pc = 32'h0;
  int                           seen = 0;
  int                           value_errors = 0;
  int                           order_errors = 0;
  int                           hold_errors = 0;

  core_frontend u_core_frontend (
    .clock             (clock),
    .reset             (reset),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .decode_stall      (decode_stall),
    .icache_addr       (icache_addr),
    .uops              (uops),
    .uop_valid         (uop_valid)
  );

  icache_model u_icache (
    .clock             (clock),
    .reset             (reset),
    .image             (image),
    .icache_addr       (icache_addr),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid)
  );

  always #10 clock = ~clock;

  function automatic logic [6:0] opcode_for(int cls);
    case (cls)
      0:       return 7'h33;
      1:       return 7'h13;
      2:       return 7'h37;
      3:       return 7'h17;
      4:       return 7'h63;
      5:       return 7'h6f;
      6:       return 7'h67;
      7:       return 7'h03;
      8:       return 7'h23;
      9:       return 7'h73;
      10:      return 7'h0f;
      default: return 7'h7f;
    endcase
  endfunction

  // decode as the RV32I spec reads, immediates by arithmetic shift
  function automatic micro_op_t reference_decode(addr_t pc, inst_t w);
    micro_op_t          r;
    logic signed [31:0] s;
    r          = '0;
    r.pc       = pc;
    r.inst     = w;
    r.rd       = w[11:7];
    r.rs1      = w[19:15];
    r.rs2      = w[24:20];
    r.uop_type = uop_illegal;
    s          = $signed(w) >>> 20;
    case (w[6:0])
      7'h33: r.uop_type = uop_alu;
      7'h13: begin
        r.uop_type = uop_alu;
        r.imm      = s;
      end
      7'h37, 7'h17: begin
        r.uop_type = uop_alu;
        r.imm      = {w[31:12], 12'h000};
      end
      7'h63: begin
        r.uop_type = uop_branch;
        s          = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'h0});
        r.imm      = s >>> 19;
      end
      7'h6f: begin
        r.uop_type = uop_branch;
        s          = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'h0});
        r.imm      = s >>> 11;
      end
      7'h67: begin
        r.uop_type = uop_branch;
        r.imm      = s;
      end
      7'h03: begin
        r.uop_type = uop_load;
        r.imm      = s;
      end
      7'h23: begin
        r.uop_type = uop_store;
        s          = $signed({w[31:25], w[11:7], 20'h0});
        r.imm      = s >>> 20;
      end
      7'h73, 7'h0f: begin
        r.uop_type = uop_system;
        r.imm      = s;
      end
      default: ;
    endcase
    r.rd_valid = (w[11:7] != 5'd0) && (r.uop_type == uop_alu || r.uop_type == uop_load ||
                                       w[6:0] == 7'h6f || w[6:0] == 7'h67);
    return r;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (expected === actual) else begin
      value_errors++;
      $display("Fail %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_lane(input int k);
    micro_op_t want;
    string     tag;
    want = reference_decode(expect_pc, image[expect_pc[7:2]]);
    tag  = $sformatf("lane%0d pc %h", k, expect_pc);
    assert (uops[k].pc === expect_pc) else begin
      order_errors++;
      $display("Fail lane%0d pc expected %h actual %h", k, expect_pc, uops[k].pc);
    end
    compare_field({tag, " inst"}, want.inst, uops[k].inst);
    compare_field({tag, " type"}, 32'(want.uop_type), 32'(uops[k].uop_type));
    compare_field({tag, " rd"}, 32'(want.rd), 32'(uops[k].rd));
    compare_field({tag, " rs1"}, 32'(want.rs1), 32'(uops[k].rs1));
    compare_field({tag, " rs2"}, 32'(want.rs2), 32'(uops[k].rs2));
    compare_field({tag, " rd_valid"}, 32'(want.rd_valid), 32'(uops[k].rd_valid));
    compare_field({tag, " imm"}, want.imm, uops[k].imm);
    expect_pc = expect_pc + 32'd4;
    seen++;
  endtask

  // outputs settle before the falling edge
  always @(negedge clock) begin
    if (reset) begin
      expect_pc  = 32'h0;
      seen       = 0;
      stall_seen = 1'b0;
    end else begin
      if (stall_seen) begin
        assert (uop_valid === prev_valid) else begin
          hold_errors++;
          $display("Fail stall hold uop_valid expected %b actual %b", prev_valid,
                   uop_valid);
        end
        assert (uops === prev_uops) else begin
          hold_errors++;
          $display("Fail stall hold uops expected %h actual %h", prev_uops, uops);
        end
      end else begin
        assert ((uop_valid & (uop_valid + DECODE_WIDTH'(1))) == '0) else begin
          order_errors++;
          $display("valid lanes not contiguous from lane 0: %b", uop_valid);
        end
        for (int k = 0; k < DECODE_WIDTH; k++) begin
          if (uop_valid[k]) begin
            check_lane(k);
          end
        end
      end
      prev_valid = uop_valid;
      prev_uops  = uops;
      stall_seen = decode_stall;
    end
  end

  task automatic drive_stall_bursts(input int target);
    int gap;
    int len;
    while (seen < target) begin
      gap = int'($urandom % 6);
      len = 1 + int'($urandom % 4);
      repeat (gap) begin
        @(posedge clock);
        decode_stall <= 1'b0;
      end
      repeat (len) begin
        @(posedge clock);
        decode_stall <= 1'b1;
      end
    end
    @(posedge clock);
    decode_stall <= 1'b0;
  endtask

  // start on an edge that accepts a line, so the buffer fills quickly
  task automatic hold_long_stall();
    addr_t frozen;
    do begin
      @(negedge clock);
    end while (!icache_data_valid);
    @(posedge clock);
    decode_stall <= 1'b1;
    repeat (10) @(posedge clock);
    @(negedge clock);
    frozen = icache_addr;
    repeat (LONG_STALL - 11) begin
      @(negedge clock);
      compare_field("long stall icache_addr", frozen, icache_addr);
    end
    @(posedge clock);
    decode_stall <= 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    clock        = 1'b0;
    reset        = 1'b1;
    decode_stall = 1'b0;
    void'($urandom(9531));
    for (int i = 0; i < N_INSTS; i++) begin
      r = $urandom;
      image[i] = {r[31:7], opcode_for(i % 12)};
      if (i % 5 == 0) begin
        image[i][11:7] = 5'd0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    compare_field("reset uop_valid", 32'h0, 32'(uop_valid));
    compare_field("reset icache_addr", RESET_PC, icache_addr);
    drive_stall_bursts(20);
    hold_long_stall();
    drive_stall_bursts(N_INSTS);
    $display("errors: value %0d, order %0d, hold %0d", value_errors, order_errors,
             hold_errors);
    if (value_errors + order_errors + hold_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("watchdog expired with %0d of %0d instructions decoded", seen, N_INSTS);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: dv/icache_model.sv
// ####################
// behavioral instruction cache over a 64-word image, addresses wrap
// line ready 1 to 3 cycles after icache_addr changes
// ####################

module icache_model (
  input  logic                   clock,
  input  logic                   reset,
  input  core_pkg::inst_t [63:0] image,
  input  core_pkg::addr_t        icache_addr,
  output core_pkg::line_t        icache_data,
  output logic                   icache_data_valid
);

  import core_pkg::*;

  logic        ready;
  addr_t       line_addr;
  line_t       line_q;
  logic [1:0]  wait_cnt;
  int unsigned lat;

  function automatic line_t read_line(addr_t a);
    line_t l;
    for (int k = 0; k < FETCH_WIDTH; k++) begin
      l[32*k +: 32] = image[a[7:2] + 6'(k)];
    end
    return l;
  endfunction

  assign icache_data       = line_q;
  // a stale line is never shown for a new address
  assign icache_data_valid = ready && (icache_addr == line_addr);

  always @(posedge clock) begin
    if (reset) begin
      ready     <= 1'b0;
      line_addr <= RESET_PC;
      line_q    <= read_line(RESET_PC);
      wait_cnt  <= 2'd2;
    end else if (icache_addr != line_addr) begin
      lat = $urandom % 3;
      line_addr <= icache_addr;
      line_q    <= read_line(icache_addr);
      ready     <= (lat == 0);
      wait_cnt  <= 2'(lat);
    end else if (!ready) begin
      wait_cnt <= wait_cnt - 2'd1;
      if (wait_cnt == 2'd1) begin
        ready <= 1'b1;
      end
    end
  end

endmodule

// File: frontend/fetch_buffer.sv
// ####################
// 16-entry circular queue, one full packet in, up to four out
// fb_full leaves room for one packet already in flight
// ####################

module fetch_buffer (
  input  logic                                           clock,
  input  logic                                           reset,
  input  core_pkg::fb_entry_t [core_pkg::FETCH_WIDTH-1:0]  fetch_insts,
  input  logic                                           fetch_valid,
  input  logic [core_pkg::POP_W-1:0]                     pop_count,
  output core_pkg::fb_entry_t [core_pkg::DECODE_WIDTH-1:0] fb_insts,
  output logic [core_pkg::DECODE_WIDTH-1:0]              fb_valid,
  output logic                                           fb_full
);

  import core_pkg::*;

  fb_entry_t               mem [FB_DEPTH];
  logic [FB_PTR_W-1:0]     head;
  logic [FB_PTR_W-1:0]     tail;
  logic [FB_PTR_W:0]       count;
  logic [FB_PTR_W:0]       free_slots;
  logic [FB_PTR_W:0]       push_n;

  assign free_slots = (FB_PTR_W + 1)'(FB_DEPTH) - count;
  assign push_n     = fetch_valid ? (FB_PTR_W + 1)'(FETCH_WIDTH) : '0;

  // one packet may still land after fetch sees this
  assign fb_full = free_slots < (FB_PTR_W + 1)'(2 * FETCH_WIDTH);

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + FB_PTR_W'(pop_count);
      count <= count + push_n - (FB_PTR_W + 1)'(pop_count);
      if (fetch_valid) begin
        tail <= tail + FB_PTR_W'(FETCH_WIDTH);
      end
    end
  end

  // pointers wrap at the depth
  always_ff @(posedge clock) begin
    if (fetch_valid) begin
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        mem[tail + FB_PTR_W'(k)] <= fetch_insts[k];
      end
    end
  end

  // oldest entries, valid bits contiguous from lane 0
  always_comb begin
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      fb_insts[k] = mem[head + FB_PTR_W'(k)];
      fb_valid[k] = count > (FB_PTR_W + 1)'(k);
    end
  end

  a_no_overflow: assert property (
    @(posedge clock) disable iff (reset)
    fetch_valid |-> free_slots >= (FB_PTR_W + 1)'(FETCH_WIDTH)
  ) else $error("packet written with only %0d free entries", free_slots);

  a_no_underflow: assert property (
    @(posedge clock) disable iff (reset)
    (FB_PTR_W + 1)'(pop_count) <= count
  ) else $error("pop of %0d with occupancy %0d", pop_count, count);

endmodule

// File: frontend/inst_fetch.sv
// ####################
// sequential fetch only, no redirect or flush
// cache data must belong to icache_addr while icache_data_valid is high
// ####################

module inst_fetch (
  input  logic                                          clock,
  input  logic                                          reset,
  input  core_pkg::line_t                               icache_data,
  input  logic                                          icache_data_valid,
  input  logic                                          fb_full,
  output core_pkg::addr_t                               icache_addr,
  output core_pkg::fb_entry_t [core_pkg::FETCH_WIDTH-1:0] fetch_insts,
  output logic                                          fetch_valid
);

  import core_pkg::*;

  logic accept;

  assign accept = icache_data_valid && !fb_full;

  // pc doubles as the cache request address
  always_ff @(posedge clock) begin
    if (reset) begin
      icache_addr <= RESET_PC;
      fetch_valid <= 1'b0;
    end else begin
      fetch_valid <= accept;
      if (accept) begin
        icache_addr <= icache_addr + addr_t'(LINE_BYTES);
      end
    end
  end

  // slot k gets word k of the line
  always_ff @(posedge clock) begin
    if (accept) begin
      for (int k = 0; k < FETCH_WIDTH; k++) begin
        fetch_insts[k].pc   <= icache_addr + addr_t'(4 * k);
        fetch_insts[k].inst <= icache_data[32*k +: 32];
      end
    end
  end

  a_line_aligned: assert property (
    @(posedge clock) disable iff (reset)
    icache_addr[$clog2(LINE_BYTES)-1:0] == '0
  ) else $error("icache_addr not line aligned: %h", icache_addr);

endmodule

// File: logic/core_frontend.sv
// ####################
// fetch, fetch buffer and decode in order
// decode_stall is the only back-pressure from downstream
// ####################

module core_frontend (
  input  logic                                           clock,
  input  logic                                           reset,
  input  core_pkg::line_t                                icache_data,
  input  logic                                           icache_data_valid,
  input  logic                                           decode_stall,
  output core_pkg::addr_t                                icache_addr,
  output core_pkg::micro_op_t [core_pkg::DECODE_WIDTH-1:0] uops,
  output logic [core_pkg::DECODE_WIDTH-1:0]              uop_valid
);

  import core_pkg::*;

  fb_entry_t [FETCH_WIDTH-1:0]  fetch_insts;
  logic                         fetch_valid;
  logic                         fb_full;
  fb_entry_t [DECODE_WIDTH-1:0] fb_insts;
  logic [DECODE_WIDTH-1:0]      fb_valid;
  logic [POP_W-1:0]             pop_count;

  inst_fetch u_inst_fetch (
    .clock             (clock),
    .reset             (reset),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .fb_full           (fb_full),
    .icache_addr       (icache_addr),
    .fetch_insts       (fetch_insts),
    .fetch_valid       (fetch_valid)
  );

  fetch_buffer u_fetch_buffer (
    .clock       (clock),
    .reset       (reset),
    .fetch_insts (fetch_insts),
    .fetch_valid (fetch_valid),
    .pop_count   (pop_count),
    .fb_insts    (fb_insts),
    .fb_valid    (fb_valid),
    .fb_full     (fb_full)
  );

  inst_decode u_inst_decode (
    .clock        (clock),
    .reset        (reset),
    .fb_insts     (fb_insts),
    .fb_valid     (fb_valid),
    .decode_stall (decode_stall),
    .pop_count    (pop_count),
    .uops         (uops),
    .uop_valid    (uop_valid)
  );

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module frontend_tb -f tb.f -o frontend_sim

./obj_dir/frontend_sim | tee sim.log

if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
exit 1

// File: tb.f
common/core_pkg.sv
frontend/inst_fetch.sv
frontend/fetch_buffer.sv
decode/inst_decode.sv
logic/core_frontend.sv
dv/icache_model.sv
dv/frontend_tb.sv
